//--- common/cpu_types_pkg.sv
// word and ram status types shared by ram and controller; byte addresses, words are 4-byte aligned
package cpu_types_pkg;

  // data path width
  localparam int WORD_W = 32;

  // one data word or one byte address
  typedef logic [WORD_W-1:0] word_t;

  // ram status as seen by the controller
  //   FREE   no request pending
  //   BUSY   request seen, latency still running
  //   ACCESS data valid / write committed this cycle
  //   ERROR  read and write asked at once
  typedef enum logic [1:0] {
    FREE   = 2'd0, // idle
    BUSY   = 2'd1, // counting latency
    ACCESS = 2'd2, // one cycle only, then back to BUSY if still requested
    ERROR  = 2'd3  // illegal ramREN & ramWEN
  } ramstate_t;

endpackage

//--- common/coherence_pkg.sv
// coherence side definitions; the controller logic is written for exactly two cores
package coherence_pkg;

  // number of cores, sizes every per-core port vector
  localparam int ncores = 2;

  // controller states
  typedef enum logic [3:0] {
    IDLE     = 4'd0, // arbitration
    WRITE_M0 = 4'd1, // writeback word 0 from serviced cache
    WRITE_M1 = 4'd2, // writeback word 1
    SNOOP    = 4'd3, // other cache stalled, waiting for its answer
    LOAD0    = 4'd4, // clean answer, block word 0 from ram
    LOAD1    = 4'd5, // clean answer, word 1
    WRITE0   = 4'd6, // dirty answer, other cache data to ram and requester
    WRITE1   = 4'd7, // dirty answer, word 1
    INSTR    = 4'd8  // single word instruction fetch
  } cc_state_t;

endpackage

//--- memory_control/memory_control.sv
// two-core arbiter and snoop controller; a data block is two words, caches hold requests as levels
`timescale 1ns/1ps

module memory_control (
  input  logic                                              CLK,
  input  logic                                              nRST,
  // instruction caches
  input  logic [coherence_pkg::ncores-1:0]                  iREN,
  input  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  iaddr,
  output logic [coherence_pkg::ncores-1:0]                  iwait,
  output cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  iload,
  // data caches
  input  logic [coherence_pkg::ncores-1:0]                  dREN,
  input  logic [coherence_pkg::ncores-1:0]                  dWEN,
  input  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  daddr,
  input  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  dstore,
  output logic [coherence_pkg::ncores-1:0]                  dwait,
  output cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  dload,
  // coherence
  input  logic [coherence_pkg::ncores-1:0]                  cctrans,
  input  logic [coherence_pkg::ncores-1:0]                  ccwrite,
  output logic [coherence_pkg::ncores-1:0]                  ccwait,
  output logic [coherence_pkg::ncores-1:0]                  ccinv,
  output cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  ccsnoopaddr,
  // ram side
  input  cpu_types_pkg::word_t                              ramload,
  input  cpu_types_pkg::ramstate_t                          ramstate,
  output logic                                              ramREN,
  output logic                                              ramWEN,
  output cpu_types_pkg::word_t                              ramaddr,
  output cpu_types_pkg::word_t                              ramstore
);

  coherence_pkg::cc_state_t state, nxt_state;

  logic [coherence_pkg::ncores-1:0]                 nxt_ccwait, nxt_ccinv;
  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0] nxt_snoopaddr;

  logic serviced, nxt_serviced; // core owning the current data transfer
  logic other;                  // the core being snooped
  logic lru, nxt_lru;           // icache that goes first when both ask
  logic icore, nxt_icore;       // icache being fetched for
  logic ram_done;               // word completes this cycle

  assign other    = ~serviced;
  assign ram_done = (ramstate == cpu_types_pkg::ACCESS);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      state       <= coherence_pkg::IDLE;
      ccwait      <= '0;
      ccinv       <= '0;
      ccsnoopaddr <= '0;
      serviced    <= 1'b0;
      lru         <= 1'b0;
      icore       <= 1'b0;
    end
    else
    begin
      state       <= nxt_state;
      ccwait      <= nxt_ccwait;
      ccinv       <= nxt_ccinv;
      ccsnoopaddr <= nxt_snoopaddr;
      serviced    <= nxt_serviced;
      lru         <= nxt_lru;
      icore       <= nxt_icore;
    end
  end

  always_comb
  begin
    // defaults: nothing on the ram, every cache stalled, loads show the ram word
    ramREN        = 1'b0;
    ramWEN        = 1'b0;
    ramaddr       = '0;
    ramstore      = '0;
    iwait         = '1;
    dwait         = '1;
    for (int c = 0; c < coherence_pkg::ncores; c++)
    begin
      iload[c] = ramload;
      dload[c] = ramload;
    end
    nxt_state     = state;
    nxt_ccwait    = ccwait;
    nxt_ccinv     = ccinv;
    nxt_snoopaddr = ccsnoopaddr;
    nxt_serviced  = serviced;
    nxt_lru       = lru;
    nxt_icore     = icore;

    case (state)
      coherence_pkg::IDLE:
      begin
        // a transition needs dREN too, so a lingering snoop answer is not taken as a request
        if (dWEN[0] && !cctrans[0]) // core 0 writeback
        begin
          nxt_serviced = 1'b0;
          nxt_state    = coherence_pkg::WRITE_M0;
        end
        else if (cctrans[0] && dREN[0]) // core 0 miss, snoop core 1
        begin
          nxt_serviced     = 1'b0;
          nxt_ccwait[1]    = 1'b1;
          nxt_snoopaddr[1] = daddr[0];
          nxt_state        = coherence_pkg::SNOOP;
        end
        else if (dWEN[1] && !cctrans[1]) // core 1 writeback
        begin
          nxt_serviced = 1'b1;
          nxt_state    = coherence_pkg::WRITE_M0;
        end
        else if (cctrans[1] && dREN[1]) // core 1 miss, snoop core 0
        begin
          nxt_serviced     = 1'b1;
          nxt_ccwait[0]    = 1'b1;
          nxt_snoopaddr[0] = daddr[1];
          nxt_state        = coherence_pkg::SNOOP;
        end
        else if (|iREN)
        begin
          if (&iREN)
            nxt_icore = lru;      // both waiting, older one first
          else
            nxt_icore = iREN[1];  // only one asks
          nxt_lru   = ~nxt_icore; // the other one is next in line
          nxt_state = coherence_pkg::INSTR;
        end
      end

      coherence_pkg::WRITE_M0, coherence_pkg::WRITE_M1:
      begin
        ramWEN   = 1'b1;
        ramaddr  = daddr[serviced]; // cache moves to word 1 after first completion
        ramstore = dstore[serviced];
        if (ram_done)
        begin
          dwait[serviced] = 1'b0;
          nxt_state = (state == coherence_pkg::WRITE_M0) ? coherence_pkg::WRITE_M1
                                                         : coherence_pkg::IDLE;
        end
      end

      coherence_pkg::SNOOP:
      begin
        if (cctrans[other]) // other cache has answered
        begin
          // dirty copy is written back and forwarded, clean block comes from ram
          nxt_state = ccwrite[other] ? coherence_pkg::WRITE0 : coherence_pkg::LOAD0;
          if (cctrans[serviced] && ccwrite[serviced])
            nxt_ccinv[other] = 1'b1; // requester wants to modify
        end
      end

      coherence_pkg::LOAD0, coherence_pkg::LOAD1:
      begin
        ramREN  = 1'b1;
        ramaddr = daddr[serviced];
        if (ram_done)
        begin
          dwait[serviced] = 1'b0; // dload already shows ramload
          nxt_state = (state == coherence_pkg::LOAD0) ? coherence_pkg::LOAD1
                                                      : coherence_pkg::IDLE;
        end
      end

      coherence_pkg::WRITE0, coherence_pkg::WRITE1:
      begin
        ramWEN          = 1'b1;
        ramaddr         = daddr[other];
        ramstore        = dstore[other];
        dload[serviced] = dstore[other]; // cache to cache forward
        if (ram_done)
        begin
          dwait[serviced] = 1'b0;
          dwait[other]    = 1'b0; // snooped cache steps to its next word as well
          nxt_state = (state == coherence_pkg::WRITE0) ? coherence_pkg::WRITE1
                                                       : coherence_pkg::IDLE;
        end
      end

      coherence_pkg::INSTR:
      begin
        ramREN  = 1'b1;
        ramaddr = iaddr[icore];
        if (ram_done)
        begin
          iwait[icore] = 1'b0;
          nxt_state    = coherence_pkg::IDLE;
        end
      end

      default: nxt_state = coherence_pkg::IDLE;
    endcase

    // snoop stall and invalidate end with the transfer
    if (nxt_state == coherence_pkg::IDLE)
    begin
      nxt_ccwait = '0;
      nxt_ccinv  = '0;
    end
  end

endmodule

//--- src/ram_model.sv
// behavioral ram, word array with fixed latency; holds address and request stable until ACCESS
`timescale 1ns/1ps

module ram_model #(
  parameter int RAM_LAT   = 2,  // BUSY cycles before each ACCESS
  parameter int RAM_WORDS = 256 // array depth in words
) (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     ramREN,
  input  logic                     ramWEN,
  input  cpu_types_pkg::word_t     ramaddr,
  input  cpu_types_pkg::word_t     ramstore,
  output cpu_types_pkg::word_t     ramload,
  output cpu_types_pkg::ramstate_t ramstate
);

  localparam int AW = $clog2(RAM_WORDS);
  localparam int CW = $clog2(RAM_LAT + 2); // at least one bit

  cpu_types_pkg::word_t mem [RAM_WORDS];
  logic [CW-1:0]        lat_cnt;   // cycles spent on the current word
  logic [AW-1:0]        widx;      // word index
  logic                 req;
  logic                 conflict;

  assign req      = ramREN | ramWEN;
  assign conflict = ramREN & ramWEN;
  assign widx     = ramaddr[AW+1:2]; // drop byte offset
  assign ramload  = mem[widx];       // always the addressed word

  always_comb
  begin
    if (conflict)
      ramstate = cpu_types_pkg::ERROR;
    else if (!req)
      ramstate = cpu_types_pkg::FREE;
    else if (lat_cnt == CW'(RAM_LAT))
      ramstate = cpu_types_pkg::ACCESS;
    else
      ramstate = cpu_types_pkg::BUSY;
  end

  // restart after every ACCESS so back-to-back words each see the full latency
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
      lat_cnt <= '0;
    else if (!req || conflict || ramstate == cpu_types_pkg::ACCESS)
      lat_cnt <= '0;
    else
      lat_cnt <= lat_cnt + 1'b1;
  end

  always @(posedge CLK)
  begin
    if (ramstate == cpu_types_pkg::ACCESS && ramWEN)
      mem[widx] <= ramstore; // commit on the access cycle
  end

  // each word starts out holding its own byte address
  initial
  begin
    for (int k = 0; k < RAM_WORDS; k++)
      mem[k] = cpu_types_pkg::word_t'(k << 2);
  end

endmodule

//--- src/memory_system.sv
// memory side of the two-core system; caches and cpus live outside, ram latency set here
`timescale 1ns/1ps

module memory_system #(
  parameter int RAM_LAT   = 2,  // ram BUSY cycles per word
  parameter int RAM_WORDS = 256 // ram depth
) (
  input  logic                                              CLK,
  input  logic                                              nRST,
  input  logic [coherence_pkg::ncores-1:0]                  iREN,
  input  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  iaddr,
  output logic [coherence_pkg::ncores-1:0]                  iwait,
  output cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  iload,
  input  logic [coherence_pkg::ncores-1:0]                  dREN,
  input  logic [coherence_pkg::ncores-1:0]                  dWEN,
  input  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  daddr,
  input  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  dstore,
  output logic [coherence_pkg::ncores-1:0]                  dwait,
  output cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  dload,
  input  logic [coherence_pkg::ncores-1:0]                  cctrans,
  input  logic [coherence_pkg::ncores-1:0]                  ccwrite,
  output logic [coherence_pkg::ncores-1:0]                  ccwait,
  output logic [coherence_pkg::ncores-1:0]                  ccinv,
  output cpu_types_pkg::word_t [coherence_pkg::ncores-1:0]  ccsnoopaddr
);

  // controller to ram
  logic                     ramREN, ramWEN;
  cpu_types_pkg::word_t     ramaddr, ramstore, ramload;
  cpu_types_pkg::ramstate_t ramstate;

  memory_control memory_control_i (
    .CLK         (CLK),
    .nRST        (nRST),
    .iREN        (iREN),
    .iaddr       (iaddr),
    .iwait       (iwait),
    .iload       (iload),
    .dREN        (dREN),
    .dWEN        (dWEN),
    .daddr       (daddr),
    .dstore      (dstore),
    .dwait       (dwait),
    .dload       (dload),
    .cctrans     (cctrans),
    .ccwrite     (ccwrite),
    .ccwait      (ccwait),
    .ccinv       (ccinv),
    .ccsnoopaddr (ccsnoopaddr),
    .ramload     (ramload),
    .ramstate    (ramstate),
    .ramREN      (ramREN),
    .ramWEN      (ramWEN),
    .ramaddr     (ramaddr),
    .ramstore    (ramstore)
  );

  ram_model #(
    .RAM_LAT   (RAM_LAT),
    .RAM_WORDS (RAM_WORDS)
  ) ram_model_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .ramREN   (ramREN),
    .ramWEN   (ramWEN),
    .ramaddr  (ramaddr),
    .ramstore (ramstore),
    .ramload  (ramload),
    .ramstate (ramstate)
  );

endmodule

//--- tb/tb_clock.sv
// clock and power-on reset for the testbench; reset is released on a falling edge
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD     = 100, // ns
  parameter int RST_CYCLES = 3    // rising edges seen with nRST low
) (
  output logic CLK,
  output logic nRST
);

  initial
  begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  initial
  begin
    nRST = 1'b0;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK); // let go between edges, clear of the flops
    nRST = 1'b1;
  end

endmodule

//--- tb/memory_control_props.sv
// output rules of memory_control, bound into every instance; written for two cores
`timescale 1ns/1ps

module memory_control_props (
  input logic                             CLK,
  input logic                             nRST,
  input logic [coherence_pkg::ncores-1:0] iwait,
  input logic [coherence_pkg::ncores-1:0] dwait,
  input logic [coherence_pkg::ncores-1:0] ccwait,
  input logic [coherence_pkg::ncores-1:0] ccinv,
  input logic                             ramREN,
  input logic                             ramWEN
);

  // one word per core per cycle, never an instruction and a data word together
  one_wait_low: assert property (@(posedge CLK) disable iff (!nRST) (~iwait & ~dwait) == '0)
    else $error("iwait and dwait low for the same core");

  // read and write strobes to the ram are exclusive
  no_ram_conflict: assert property (@(posedge CLK) disable iff (!nRST) !(ramREN && ramWEN))
    else $error("ramREN and ramWEN high together");

  // invalidate only goes to a cache that is stalled for the snoop
  inv_under_wait: assert property (@(posedge CLK) disable iff (!nRST) (ccinv & ~ccwait) == '0)
    else $error("ccinv high without ccwait");

endmodule

bind memory_control memory_control_props props_i (
  .CLK    (CLK),
  .nRST   (nRST),
  .iwait  (iwait),
  .dwait  (dwait),
  .ccwait (ccwait),
  .ccinv  (ccinv),
  .ramREN (ramREN),
  .ramWEN (ramWEN)
);

//--- tb/memory_system_tb.sv
// directed tests playing both cores' caches; ram words 0..127 are only read, writes go above
`timescale 1ns/1ps

module memory_system_tb;

  localparam int RAM_LAT   = 2;
  localparam int RAM_WORDS = 256;
  localparam int TIMEOUT   = 4000; // cycles, the tests need a few hundred
  localparam int WAIT_MAX  = 20;   // per handshake, far above RAM_LAT + 2
  localparam logic [1:0] EV_I = 2'd0; // iwait low
  localparam logic [1:0] EV_D = 2'd1; // dwait low
  localparam logic [1:0] EV_S = 2'd2; // ccwait high, snoop arrives

  logic CLK, nRST;
  logic [coherence_pkg::ncores-1:0] iren, dren, dwen, cctrans, ccwrite;
  logic [coherence_pkg::ncores-1:0] iwait, dwait, ccwait, ccinv;
  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0] iaddr, daddr, dstore;
  cpu_types_pkg::word_t [coherence_pkg::ncores-1:0] iload, dload, ccsnoopaddr;

  int   errors, tests_run, tests_failed, cycles;
  logic last_icore; // core whose fetch completed last

  tb_clock #(.PERIOD(100), .RST_CYCLES(3)) clock_i (.CLK(CLK), .nRST(nRST));

  memory_system #(.RAM_LAT(RAM_LAT), .RAM_WORDS(RAM_WORDS)) dut_i (
    .CLK(CLK), .nRST(nRST),
    .iREN(iren), .iaddr(iaddr), .iwait(iwait), .iload(iload),
    .dREN(dren), .dWEN(dwen), .daddr(daddr), .dstore(dstore), .dwait(dwait), .dload(dload),
    .cctrans(cctrans), .ccwrite(ccwrite), .ccwait(ccwait), .ccinv(ccinv),
    .ccsnoopaddr(ccsnoopaddr)
  );

  function automatic cpu_types_pkg::word_t rand_addr(input int lo, input int hi);
    return cpu_types_pkg::word_t'($urandom_range(hi, lo)) << 2; // word index to byte address
  endfunction

  task automatic report_mismatch(input string name, input cpu_types_pkg::word_t got,
                                 input cpu_types_pkg::word_t exp);
    $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start)
      $display("%0t ns: test %s ok", $time, name);
    else
    begin
      tests_failed++;
      $display("%0t ns: test %s FAILED, %0d errors", $time, name, errors - errs_at_start);
    end
  endtask

  // steps falling edges until the event shows, stops at WAIT_MAX
  task automatic wait_for(input logic [1:0] what, input logic core, output bit seen);
    int n;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_MAX)
    begin
      @(negedge CLK);
      n++;
      case (what)
        EV_I:    seen = !iwait[core];
        EV_D:    seen = !dwait[core];
        default: seen = ccwait[core];
      endcase
    end
    if (!seen)
    begin
      $display("ERROR at %0t ns: core %0d, event %0d did not come", $time, core, what);
      errors++;
    end
  endtask

  // one instruction word; request dropped in the completion cycle
  task automatic fetch_word(input logic core, input cpu_types_pkg::word_t addr,
                            output cpu_types_pkg::word_t data);
    bit seen;
    iren[core]  = 1'b1;
    iaddr[core] = addr;
    wait_for(EV_I, core, seen);
    data = iload[core]; // valid while iwait is low
    if (seen)
      last_icore = core;
    iren[core] = 1'b0;
  endtask

  task automatic test_reset_values();
    int e0;
    e0 = errors;
    if (iwait !== 2'b11) report_mismatch("iwait", 32'(iwait), 32'd3);
    if (dwait !== 2'b11) report_mismatch("dwait", 32'(dwait), 32'd3);
    if (ccwait !== 2'b00) report_mismatch("ccwait", 32'(ccwait), 32'd0);
    if (ccinv !== 2'b00) report_mismatch("ccinv", 32'(ccinv), 32'd0);
    finish_test("reset_values", e0);
  endtask

  // untouched ram word holds its own address
  task automatic test_single_fetch();
    int e0;
    int c;
    cpu_types_pkg::word_t a, d;
    e0 = errors;
    for (c = 0; c < 2; c++)
    begin
      a = rand_addr(0, 127);
      fetch_word(c[0], a, d);
      if (d !== a) report_mismatch($sformatf("iload[%0d]", c), d, a);
    end
    finish_test("single_fetch", e0);
  endtask

  // both cores keep iREN up for two fetches each, service must alternate
  task automatic test_lru_fetch();
    int e0;
    int n;
    int served [2];
    logic j, k;
    e0        = errors;
    n         = 0;
    served[0] = 0;
    served[1] = 0;
    k         = ~last_icore; // not served last, so first in line
    iaddr[0]  = rand_addr(0, 127);
    iaddr[1]  = rand_addr(0, 127);
    iren      = 2'b11;
    while (served[0] + served[1] < 4 && n < 4 * WAIT_MAX)
    begin
      @(negedge CLK);
      n++;
      if (!(&iwait))
      begin
        j = iwait[0]; // low bit still waiting means core 1 finished
        if (j !== k)
        begin
          $display("ERROR at %0t ns: core %0d served out of LRU order", $time, j);
          errors++;
        end
        if (iload[j] !== iaddr[j]) report_mismatch($sformatf("iload[%0d]", j), iload[j], iaddr[j]);
        served[j]++;
        if (served[j] == 2)
          iren[j] = 1'b0;
        else
          iaddr[j] = rand_addr(0, 127);
        last_icore = j;
        k          = ~j;
      end
    end
    if (iren !== 2'b00)
    begin
      $display("ERROR at %0t ns: alternating fetches did not all finish", $time);
      errors++;
      iren = '0;
    end
    finish_test("lru_fetch", e0);
  endtask

  // core 1 writes a block back, core 0 fetches it as instructions
  task automatic test_writeback_fetch();
    int e0;
    bit seen;
    cpu_types_pkg::word_t base, d0, d1, r;
    e0        = errors;
    base      = rand_addr(128, 190);
    d0        = $urandom;
    d1        = $urandom;
    dwen[1]   = 1'b1;
    daddr[1]  = base;
    dstore[1] = d0;
    wait_for(EV_D, 1'b1, seen);
    @(negedge CLK); // ram commits word 0 on the edge that ends its access cycle
    daddr[1]  = base + 4; // word 1 after the first completion
    dstore[1] = d1;
    wait_for(EV_D, 1'b1, seen);
    dwen[1] = 1'b0;
    fetch_word(1'b0, base, r);
    if (r !== d0) report_mismatch("iload[0]", r, d0);
    fetch_word(1'b0, base + 4, r);
    if (r !== d1) report_mismatch("iload[0]", r, d1);
    finish_test("writeback_fetch", e0);
  endtask

  // core 0 read miss, core 1 answers clean, block comes from ram
  task automatic test_clean_snoop();
    int e0;
    int w;
    bit seen;
    cpu_types_pkg::word_t a;
    e0         = errors;
    a          = rand_addr(0, 126);
    dren[0]    = 1'b1;
    cctrans[0] = 1'b1;
    ccwrite[0] = 1'b0;
    daddr[0]   = a;
    wait_for(EV_S, 1'b1, seen);
    if (ccsnoopaddr[1] !== a) report_mismatch("ccsnoopaddr[1]", ccsnoopaddr[1], a);
    cctrans[1] = 1'b1; // answer with ccwrite low, no dirty copy
    ccwrite[1] = 1'b0;
    for (w = 0; w < 2; w++)
    begin
      wait_for(EV_D, 1'b0, seen);
      if (dload[0] !== daddr[0]) report_mismatch("dload[0]", dload[0], daddr[0]);
      if (ccwait[1] !== 1'b1) report_mismatch("ccwait[1]", 32'(ccwait[1]), 32'd1);
      if (ccinv[1] !== 1'b0) report_mismatch("ccinv[1]", 32'(ccinv[1]), 32'd0);
      daddr[0] = a + 4;
    end
    dren[0] = 1'b0;
    cctrans = '0;
    @(negedge CLK);
    if (ccwait !== 2'b00) report_mismatch("ccwait", 32'(ccwait), 32'd0); // back in idle
    finish_test("clean_snoop", e0);
  endtask

  // core 1 write miss, core 0 holds the block dirty and supplies it
  task automatic test_dirty_snoop();
    int e0;
    int w;
    bit seen;
    cpu_types_pkg::word_t b, d0, d1, exp, r;
    e0         = errors;
    b          = rand_addr(192, 254);
    d0         = $urandom;
    d1         = $urandom;
    dren[1]    = 1'b1;
    cctrans[1] = 1'b1;
    ccwrite[1] = 1'b1; // wants to modify
    daddr[1]   = b;
    wait_for(EV_S, 1'b0, seen);
    if (ccsnoopaddr[0] !== b) report_mismatch("ccsnoopaddr[0]", ccsnoopaddr[0], b);
    cctrans[0] = 1'b1;
    ccwrite[0] = 1'b1; // dirty answer
    daddr[0]   = b;
    dstore[0]  = d0;
    for (w = 0; w < 2; w++)
    begin
      exp = (w == 0) ? d0 : d1;
      wait_for(EV_D, 1'b1, seen);
      if (dload[1] !== exp) report_mismatch("dload[1]", dload[1], exp);
      if (ccinv[0] !== 1'b1) report_mismatch("ccinv[0]", 32'(ccinv[0]), 32'd1);
      if (dwait[0] !== 1'b0) report_mismatch("dwait[0]", 32'(dwait[0]), 32'd0);
      if (w == 0)
      begin
        @(negedge CLK); // dirty word 0 goes to ram on the edge after its access
        daddr[1]  = b + 4;
        daddr[0]  = b + 4;
        dstore[0] = d1;
      end
    end
    dren[1] = 1'b0;
    cctrans = '0;
    ccwrite = '0;
    @(negedge CLK);
    if (ccinv !== 2'b00) report_mismatch("ccinv", 32'(ccinv), 32'd0);
    fetch_word(1'b1, b, r); // ram took the dirty block too
    if (r !== d0) report_mismatch("iload[1]", r, d0);
    fetch_word(1'b1, b + 4, r);
    if (r !== d1) report_mismatch("iload[1]", r, d1);
    finish_test("dirty_snoop", e0);
  endtask

  initial
  begin
    void'($urandom(79119)); // one seed for the run
    iren         = '0;
    iaddr        = '0;
    dren         = '0;
    dwen         = '0;
    daddr        = '0;
    dstore       = '0;
    cctrans      = '0;
    ccwrite      = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    last_icore   = 1'b1; // lru resets to core 0 first
    @(posedge nRST);
    @(negedge CLK);
    test_reset_values();
    test_single_fetch();
    test_lru_fetch();
    test_writeback_fetch();
    test_clean_snoop();
    test_dirty_snoop();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // watchdog over the whole run
  initial
  begin
    cycles = 0;
    while (cycles < TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
    end
    $display("ERROR: run stopped after %0d cycles, a test is stuck", cycles);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- memory_system.f
common/cpu_types_pkg.sv
common/coherence_pkg.sv
memory_control/memory_control.sv
src/ram_model.sv
src/memory_system.sv
tb/tb_clock.sv
tb/memory_control_props.sv
tb/memory_system_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module memory_system_tb \
  -f memory_system.f -o memory_system_sim || { echo "build failed"; exit 1; }
./obj_dir/memory_system_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "^Testbench passed$" sim.log && { echo "result: pass"; exit 0; } || { echo "result: fail"; exit 1; }
